// File: logic/disp_pkg.sv
/* hex display controller definitions */

`default_nettype none

package disp_pkg;

   // display geometry
   localparam int num_digits = 4;
   localparam int digit_w    = 4;    // one hex nibble per digit

   // AXI4-Lite bus sizes
   localparam int addr_w = 4;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   // register map
   localparam logic [addr_w-1:0] reg_digits   = 4'h0;  // four nibbles, digit 0 lowest
   localparam logic [addr_w-1:0] reg_ctrl     = 4'h4;  // [3:0] dp enable, [7:4] blank
   localparam logic [addr_w-1:0] reg_prescale = 4'h8;  // clocks per slot minus one

   // scan prescaler
   localparam int prescale_w = 16;
   localparam logic [prescale_w-1:0] prescale_rst = 16'hffff;

   // bus response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // active-low segments gfedcba, indexed by nibble
   localparam logic [6:0] seg_font [0:15] = '{
      7'b1000000,  // 0
      7'b1111001,  // 1
      7'b0100100,  // 2
      7'b0110000,  // 3
      7'b0011001,  // 4
      7'b0010010,  // 5
      7'b0000010,  // 6
      7'b1111000,  // 7
      7'b0000000,  // 8
      7'b0010000,  // 9
      7'b0001000,  // a
      7'b0000011,  // b
      7'b1000110,  // c
      7'b0100001,  // d
      7'b0000110,  // e
      7'b0001110   // f
   };

endpackage

`default_nettype wire

// File: logic/disp_cfg_if.sv
/* display configuration link */

`timescale 1ns/1ps
`default_nettype none

interface disp_cfg_if;

   // hex value of every digit, digit 0 in the low nibble
   logic [disp_pkg::num_digits*disp_pkg::digit_w-1:0] digits;
   logic [disp_pkg::num_digits-1:0]                  dp_en;     // decimal point per digit
   logic [disp_pkg::num_digits-1:0]                  blank;     // 1 = digit dark
   logic [disp_pkg::prescale_w-1:0]                  prescale;  // slot length minus one

   // register side owns the values
   modport regs (
      output digits,
      output dp_en,
      output blank,
      output prescale
   );

   // scanner only samples them at slot boundaries
   modport scan (
      input digits,
      input dp_en,
      input blank,
      input prescale
   );

endinterface

`default_nettype wire

// File: logic/disp_axil_regs.sv
/* display registers, AXI4-Lite slave */

`timescale 1ns/1ps
`default_nettype none

module disp_axil_regs (
   input  wire                              clk,
   input  wire                              reset,
   // write address and data
   input  wire  [disp_pkg::addr_w-1:0]      awaddr,
   input  wire                              awvalid,
   output logic                             awready,
   input  wire  [disp_pkg::data_w-1:0]      wdata,
   input  wire  [disp_pkg::strb_w-1:0]      wstrb,
   input  wire                              wvalid,
   output logic                             wready,
   // write response
   output logic [1:0]                       bresp,
   output logic                             bvalid,
   input  wire                              bready,
   // read
   input  wire  [disp_pkg::addr_w-1:0]      araddr,
   input  wire                              arvalid,
   output logic                             arready,
   output logic [disp_pkg::data_w-1:0]      rdata,
   output logic [1:0]                       rresp,
   output logic                             rvalid,
   input  wire                              rready,
   // configuration towards the scanner
   disp_cfg_if.regs                         cfg
);

   logic [15:0]                     digits_q;
   logic [7:0]                      ctrl_q;     // blank in the high nibble
   logic [disp_pkg::prescale_w-1:0] prescale_q;
   logic                            wr_accept;  // drives awready and wready together
   logic                            wr_go;
   logic                            rd_go;

   // true for the three mapped, word aligned addresses
   function automatic logic addr_hit(input logic [disp_pkg::addr_w-1:0] addr);
      addr_hit = (addr == disp_pkg::reg_digits) ||
                 (addr == disp_pkg::reg_ctrl) ||
                 (addr == disp_pkg::reg_prescale);
   endfunction

   // byte strobed update of a 16 bit field
   function automatic logic [15:0] merge16(input logic [15:0] old_val,
                                           input logic [15:0] new_val,
                                           input logic [1:0]  strb);
      merge16 = old_val;
      if (strb[0])
         merge16[7:0] = new_val[7:0];
      if (strb[1])
         merge16[15:8] = new_val[15:8];
   endfunction

   assign awready = wr_accept;
   assign wready  = wr_accept;
   assign wr_go   = wr_accept && awvalid && wvalid;
   assign rd_go   = arready && arvalid;

   // one cycle ready pulse once both write halves are present
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_accept <= 1'b0;
         bvalid    <= 1'b0;
      end
      else
      begin
         wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
         if (wr_go)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;  // response taken
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_go)
         bresp <= addr_hit(awaddr) ? disp_pkg::resp_okay : disp_pkg::resp_slverr;
   end

   // register file updates together with bvalid rising
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         digits_q   <= '0;
         ctrl_q     <= '0;
         prescale_q <= disp_pkg::prescale_rst;
      end
      else if (wr_go)
      begin
         case (awaddr)
            disp_pkg::reg_digits:
               digits_q <= merge16(digits_q, wdata[15:0], wstrb[1:0]);
            disp_pkg::reg_ctrl:
               if (wstrb[0])
                  ctrl_q <= wdata[7:0];
            disp_pkg::reg_prescale:
               prescale_q <= merge16(prescale_q, wdata[15:0], wstrb[1:0]);
            default:
               ;  // unmapped address stores nothing
         endcase
      end
   end

   // read channel
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end
      else
      begin
         arready <= arvalid && !arready && !rvalid;
         if (rd_go)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_go)
      begin
         rresp <= disp_pkg::resp_okay;
         case (araddr)
            disp_pkg::reg_digits:   rdata <= {16'h0000, digits_q};
            disp_pkg::reg_ctrl:     rdata <= {24'h000000, ctrl_q};
            disp_pkg::reg_prescale: rdata <= {16'h0000, prescale_q};
            default:
            begin
               rdata <= '0;
               rresp <= disp_pkg::resp_slverr;
            end
         endcase
      end
   end

   // held registers feed the scanner as plain levels
   assign cfg.digits   = digits_q;
   assign cfg.dp_en    = ctrl_q[3:0];
   assign cfg.blank    = ctrl_q[7:4];
   assign cfg.prescale = prescale_q;

endmodule

`default_nettype wire

// File: logic/disp_scan_mux.sv
/* digit scanner and segment decoder */

`timescale 1ns/1ps
`default_nettype none

module disp_scan_mux (
   input  wire                              clk,
   input  wire                              reset,
   disp_cfg_if.scan                         cfg,
   output logic [disp_pkg::num_digits-1:0]  an,    // active low digit enables
   output logic [7:0]                       sseg   // active low with dp in bit 7
);

   logic [disp_pkg::prescale_w-1:0] tick_cnt;
   logic                            tick;       // last cycle of a slot
   logic [1:0]                      digit_idx;  // digit currently shown
   logic [1:0]                      next_idx;   // digit of the coming slot
   logic [disp_pkg::digit_w-1:0]    nibble;
   logic                            dp_on;
   logic                            blank_on;
   logic [disp_pkg::num_digits-1:0] an_next;
   logic [7:0]                      sseg_next;

   // >= so a prescale lowered mid slot ends the slot at once
   assign tick     = (tick_cnt >= cfg.prescale);
   assign next_idx = digit_idx + 2'd1;

   // slot timer and digit index
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         tick_cnt  <= '0;
         digit_idx <= 2'd3;  // first tick moves to digit 0
      end
      else if (tick)
      begin
         tick_cnt  <= '0;
         digit_idx <= next_idx;
      end
      else
      begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   // pick the coming digit's settings and decode them
   always_comb
   begin
      nibble   = cfg.digits[disp_pkg::digit_w*next_idx +: disp_pkg::digit_w];
      dp_on    = cfg.dp_en[next_idx];
      blank_on = cfg.blank[next_idx];

      if (blank_on)
      begin
         an_next   = '1;  // dark slot
         sseg_next = '1;
      end
      else
      begin
         an_next   = ~(4'b0001 << next_idx);
         sseg_next = {~dp_on, disp_pkg::seg_font[nibble]};
      end
   end

   /* outputs only change at a slot boundary
      and come straight from flops, so no decode glitches reach the pins */
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         an   <= '1;
         sseg <= '1;
      end
      else if (tick)
      begin
         an   <= an_next;
         sseg <= sseg_next;
      end
   end

endmodule

`default_nettype wire

// File: logic/disp_hex_ctrl.sv
/* hex display controller top */

`timescale 1ns/1ps
`default_nettype none

module disp_hex_ctrl (
   input  wire                              clk,
   input  wire                              reset,
   // AXI4-Lite write
   input  wire  [disp_pkg::addr_w-1:0]      awaddr,
   input  wire                              awvalid,
   output logic                             awready,
   input  wire  [disp_pkg::data_w-1:0]      wdata,
   input  wire  [disp_pkg::strb_w-1:0]      wstrb,
   input  wire                              wvalid,
   output logic                             wready,
   output logic [1:0]                       bresp,
   output logic                             bvalid,
   input  wire                              bready,
   // AXI4-Lite read
   input  wire  [disp_pkg::addr_w-1:0]      araddr,
   input  wire                              arvalid,
   output logic                             arready,
   output logic [disp_pkg::data_w-1:0]      rdata,
   output logic [1:0]                       rresp,
   output logic                             rvalid,
   input  wire                              rready,
   // display pins
   output logic [disp_pkg::num_digits-1:0]  an,
   output logic [7:0]                       sseg
);

   disp_cfg_if cfg_if ();  // register block to scanner

   disp_axil_regs regs_i (
      .clk     (clk),
      .reset   (reset),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .cfg     (cfg_if.regs)
   );

   disp_scan_mux scan_i (
      .clk   (clk),
      .reset (reset),
      .cfg   (cfg_if.scan),
      .an    (an),
      .sseg  (sseg)
   );

endmodule

`default_nettype wire

// File: testbench/disp_scan_chk.sv
/* scan output assertions */

`timescale 1ns/1ps
`default_nettype none

module disp_scan_chk (
   input wire       clk,
   input wire       reset,
   input wire [3:0] an,
   input wire [1:0] digit_idx,
   input wire       tick
);

   int assert_errs = 0;  // failed assertions so far

   one_digit_on: assert property (@(posedge clk) disable iff (reset) $countones(~an) <= 1)
   else
   begin
      $error("more than one anode enabled: an = %b", an);
      assert_errs++;
   end

   // index only moves at a slot boundary
   idx_on_tick: assert property (@(posedge clk) disable iff (reset)
                                 !$past(tick) |-> $stable(digit_idx))
   else
   begin
      $error("digit index changed without a tick");
      assert_errs++;
   end

   dark_in_reset: assert property (@(posedge clk) reset |-> an == 4'hf)
   else
   begin
      $error("anodes not all off during reset: an = %b", an);
      assert_errs++;
   end

endmodule

bind disp_scan_mux disp_scan_chk scan_chk_i (
   .clk       (clk),
   .reset     (reset),
   .an        (an),
   .digit_idx (digit_idx),
   .tick      (tick)
);

`default_nettype wire

// File: testbench/disp_monitor.sv
/* bus and display checker */

`timescale 1ns/1ps
`default_nettype none

module disp_monitor (
   input  wire         clk,
   input  wire         bvalid,
   input  wire         bready,
   input  wire  [1:0]  bresp,
   input  wire         rvalid,
   input  wire         rready,
   input  wire  [31:0] rdata,
   input  wire  [1:0]  rresp,
   input  wire  [3:0]  an,
   input  wire  [7:0]  sseg,
   input  int          test_seq,  // number of tests posted so far
   input  wire  [3:0]  t_kind,
   input  wire  [3:0]  t_arg,
   input  wire  [31:0] t_data,    // rdata, or sseg in the low byte
   input  wire  [3:0]  t_mask,    // expected an for scan tests
   input  wire  [1:0]  t_resp,
   output int          done_cnt,
   output int          pass_cnt,
   output int          fail_cnt
);

   function automatic bit same_val(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   // waits for an[d] to fall at the start of a fresh slot
   task automatic wait_fall(input logic [1:0] d);
      logic last;
      @(negedge clk);
      last = an[d];
      @(negedge clk);
      while (!(last && !an[d]))
      begin
         last = an[d];
         @(negedge clk);
      end
   endtask

   initial
   begin
      bit         ok;
      logic [1:0] prev;
      string      label;
      done_cnt = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      forever
      begin
         wait (test_seq > done_cnt);
         ok = 1'b1;
         case (t_kind)
            4'h1:
            begin
               label = "write";
               do @(negedge clk); while (!(bvalid && bready));
               ok = same_val("bresp", 32'(bresp), 32'(t_resp));
            end
            4'h2:
            begin
               label = "read";
               do @(negedge clk); while (!(rvalid && rready));
               ok = same_val("rdata", rdata, t_data);
               if (!same_val("rresp", 32'(rresp), 32'(t_resp)))
                  ok = 1'b0;
            end
            default:
            begin
               label = "scan";
               prev  = t_arg[1:0] - 2'd1;
               if (t_mask == 4'hf)
               begin
                  // a dark digit's slot follows the previous digit's slot
                  wait_fall(prev);
                  while (!an[prev])
                     @(negedge clk);
               end
               else
                  wait_fall(t_arg[1:0]);
               ok = same_val("an", 32'(an), 32'(t_mask));
               if (!same_val("sseg", 32'(sseg), 32'(t_data[7:0])))
                  ok = 1'b0;
            end
         endcase
         if (ok)
            pass_cnt++;
         else
            fail_cnt++;
         $display("test %0d %s at %h: %s", done_cnt + 1, label, t_arg, ok ? "ok" : "mismatch");
         done_cnt++;
      end
   end

endmodule

`default_nettype wire

// File: testbench/disp_hex_ctrl_tb.sv
/* hex display controller testbench */

`timescale 1ns/1ps
`default_nettype none

module disp_hex_ctrl_tb;

   localparam int max_tests = 64;

   logic                        clk;
   logic                        reset;
   logic [disp_pkg::addr_w-1:0] awaddr;
   logic [disp_pkg::addr_w-1:0] araddr;
   logic [disp_pkg::data_w-1:0] wdata;
   logic [disp_pkg::data_w-1:0] rdata;
   logic [disp_pkg::strb_w-1:0] wstrb;
   logic                        awvalid;
   logic                        awready;
   logic                        wvalid;
   logic                        wready;
   logic                        bvalid;
   logic                        bready;
   logic                        arvalid;
   logic                        arready;
   logic                        rvalid;
   logic                        rready;
   logic [1:0]                  bresp;
   logic [1:0]                  rresp;
   logic [3:0]                  an;
   logic [7:0]                  sseg;

   logic [47:0] tests [0:max_tests-1];  // kind, addr, data, mask, resp
   logic [3:0]  t_kind;
   logic [3:0]  t_arg;                  // address or digit for scan tests
   logic [31:0] t_data;
   logic [3:0]  t_mask;                 // wstrb or expected an
   logic [1:0]  t_resp;
   int          test_seq;
   int          n_tests;
   int          limit = 0;
   int          cycles = 0;
   int          done_cnt;
   int          pass_cnt;
   int          fail_cnt;

   disp_hex_ctrl dut_i (.*);

   disp_monitor mon_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // hang guard with its limit taken from the test file
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("timeout: tests did not finish within %0d clock cycles", limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      do @(negedge clk); while (!(awready && wready));
      @(posedge clk);  // address and data accepted here
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(negedge clk); while (!bvalid);
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] addr);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      do @(negedge clk); while (!rvalid);
      @(posedge clk);
      rready <= 1'b0;
   endtask

   initial
   begin
      logic [15:0] max_ps;
      int          errs;
      reset    <= 1'b1;
      awaddr   <= '0;
      awvalid  <= 1'b0;
      wdata    <= '0;
      wstrb    <= '0;
      wvalid   <= 1'b0;
      bready   <= 1'b0;
      araddr   <= '0;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      test_seq <= 0;

      $readmemh("testbench/disp_tests.dat", tests);
      n_tests = 0;
      max_ps  = '0;
      while (n_tests < max_tests && tests[n_tests][47:44] inside {4'h1, 4'h2, 4'h3})
      begin
         if (tests[n_tests][47:40] == 8'h18 && tests[n_tests][23:8] > max_ps)
            max_ps = tests[n_tests][23:8];  // prescale write
         n_tests++;
      end
      limit = n_tests * 4 * (int'(max_ps) + 1) + 200;

      repeat (8) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < n_tests; i++)
      begin
         @(posedge clk);
         t_kind   <= tests[i][47:44];
         t_arg    <= tests[i][43:40];
         t_data   <= tests[i][39:8];
         t_mask   <= tests[i][7:4];
         t_resp   <= tests[i][1:0];
         test_seq <= i + 1;  // hands the expectation to the monitor
         case (tests[i][47:44])
            4'h1:    axi_write(tests[i][43:40], tests[i][39:8], tests[i][7:4]);
            4'h2:    axi_read(tests[i][43:40]);
            default: ;  // scan tests only watch the pins
         endcase
         wait (done_cnt == i + 1);
      end

      @(posedge clk);
      errs = dut_i.scan_i.scan_chk_i.assert_errs;
      $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion errors",
               done_cnt, pass_cnt, fail_cnt, errs);
      if (n_tests > 0 && pass_cnt == n_tests && fail_cnt == 0 && errs == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/disp_tests.dat
// kind_addr_data_mask_resp: kind 1 write (mask = wstrb), kind 2 read (data = rdata)
// kind 3 scan: addr = digit, data = sseg, mask = an; resp = bresp or rresp
2_8_0000ffff_0_0
2_0_00000000_0_0
2_4_00000000_0_0
1_0_00001234_f_0
1_0_ffffab00_2_0
2_0_0000ab34_0_0
1_c_12345678_f_2
2_c_00000000_0_2
1_8_00000003_f_0
3_0_00000099_e_0
3_1_000000b0_d_0
3_2_00000083_b_0
3_3_00000088_7_0
1_0_00005210_f_0
3_0_000000c0_e_0
3_1_000000f9_d_0
3_2_000000a4_b_0
3_3_00000092_7_0
1_0_00009876_f_0
3_0_00000082_e_0
3_1_000000f8_d_0
3_2_00000080_b_0
3_3_00000090_7_0
1_0_0000fedc_f_0
3_0_000000c6_e_0
3_1_000000a1_d_0
3_2_00000086_b_0
3_3_0000008e_7_0
1_4_00000085_f_0
3_0_00000046_e_0
3_1_000000a1_d_0
3_2_00000006_b_0
3_3_000000ff_f_0
2_4_00000085_0_0

// File: disp_hex_ctrl.f
logic/disp_pkg.sv
logic/disp_cfg_if.sv
logic/disp_axil_regs.sv
logic/disp_scan_mux.sv
logic/disp_hex_ctrl.sv
testbench/disp_scan_chk.sv
testbench/disp_monitor.sv
testbench/disp_hex_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the hex display testbench under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module disp_hex_ctrl_tb \
   -f disp_hex_ctrl.f -o disp_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

# keep running past the first assertion error so the testbench reports it
./obj_dir/disp_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1
